/* src/icache_config.svh */
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

////////////////////
// Cache geometry
////////////////////

// Direct-mapped, one 64-bit block per line
`define ICACHE_LINES 32
`define ICACHE_INDEX_BITS 5

// Highest address bit compared, bits above it are ignored
`define ICACHE_ADDR_TOP 15

// Tag is bits 15 down to 8
`define ICACHE_TAG_BITS 8

// Memory transaction tag, zero means no transaction
`define MEM_TAG_BITS 4

////////////////////
// Register map
////////////////////

`define CSR_CTRL 2'd0
`define CSR_HITS 2'd1
`define CSR_MISSES 2'd2

`endif

/* src/icache_pkg.sv */
`include "icache_config.svh"

package icache_pkg;

    // Byte address from fetch
    typedef logic [31:0] addr_t;

    // One cache block, also the memory transfer unit
    typedef logic [63:0] mem_block_t;

    // Memory transaction tag
    typedef logic [`MEM_TAG_BITS-1:0] mem_tag_t;

    // Line number and stored tag
    typedef logic [`ICACHE_INDEX_BITS-1:0] line_index_t;
    typedef logic [`ICACHE_TAG_BITS-1:0] cache_tag_t;

    // Statistics counters
    typedef logic [31:0] count_t;

    // Memory request command
    typedef enum logic [1:0] {
        MEM_NONE = 2'h0,
        MEM_LOAD = 2'h1
    } mem_command_t;

    // Register port handshake
    typedef enum logic [1:0] {
        CSR_IDLE      = 2'h0,
        CSR_ACK       = 2'h1,
        CSR_WAIT_DROP = 2'h2
    } csr_state_t;

endpackage

/* src/icache_data_array.sv */
`include "icache_config.svh"

module icache_data_array (
    input  logic                     clock,
    input  icache_pkg::line_index_t  read_index,
    output icache_pkg::mem_block_t   read_data,
    input  logic                     fill,
    input  icache_pkg::mem_block_t   fill_data
);

    import icache_pkg::*;

    ////////////////////
    // Block storage
    ////////////////////

    // One block per line, valid bits live in the tag store
    mem_block_t blocks [`ICACHE_LINES];

    // Asynchronous read of the addressed line
    assign read_data = blocks[read_index];

    // Fill writes the line being fetched
    // Fill address equals the read address by construction
    always_ff @(posedge clock) begin
        if (fill) begin
            blocks[read_index] <= fill_data;
        end
    end

endmodule

/* src/icache_tag_store.sv */
`include "icache_config.svh"

module icache_tag_store (
    input  logic               clock,
    input  logic               reset,
    input  logic               flush,
    input  icache_pkg::addr_t  addr,
    input  logic               fill,
    output logic               hit,
    output icache_pkg::addr_t  next_invalid_line
);

    import icache_pkg::*;

    ////////////////////
    // Address split
    ////////////////////

    line_index_t cur_index;
    cache_tag_t  cur_tag;

    // Index is bits 7..3, tag is bits 15..8
    assign cur_index = addr[`ICACHE_INDEX_BITS+2:3];
    assign cur_tag   = addr[`ICACHE_ADDR_TOP:`ICACHE_INDEX_BITS+3];

    ////////////////////
    // Line state
    ////////////////////

    logic [`ICACHE_LINES-1:0] valid;
    cache_tag_t               tags [`ICACHE_LINES];

    // Flush has priority over a fill on the same edge
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            valid <= '0;
        end else if (fill) begin
            valid[cur_index] <= 1'b1;
        end
    end

    // Tag payload, guarded by the valid bit
    always_ff @(posedge clock) begin
        if (fill) begin
            tags[cur_index] <= cur_tag;
        end
    end

    // Same-cycle hit compare
    assign hit = valid[cur_index] && (tags[cur_index] == cur_tag);

    ////////////////////
    // Next invalid line
    ////////////////////

    line_index_t nil_index;
    cache_tag_t  nil_tag;

    always_comb begin
        line_index_t probe;
        logic        found;
        found     = 1'b0;
        probe     = cur_index;
        // No invalid line: point at the same index in the next tag block
        nil_index = cur_index;
        nil_tag   = cur_tag + 1'b1;
        // Walk upward from the current index, 5-bit add wraps
        for (int i = 0; i < `ICACHE_LINES; i++) begin
            probe = cur_index + line_index_t'(i);
            if (!found && !valid[probe]) begin
                found     = 1'b1;
                nil_index = probe;
                // Wrapped below the start means the next tag block
                nil_tag   = (probe < cur_index) ? cur_tag + 1'b1 : cur_tag;
            end
        end
    end

    // Upper address bits pass through, block offset cleared
    assign next_invalid_line = {addr[31:`ICACHE_ADDR_TOP+1], nil_tag, nil_index, 3'b000};

    // Miss controller only fills a line that is missing
    assert property (@(posedge clock) disable iff (reset) fill |-> !hit)
        else $error("icache_tag_store: fill on a line that already hits");

endmodule

/* src/icache_miss_ctrl.sv */
`include "icache_config.svh"

module icache_miss_ctrl (
    input  logic                      clock,
    input  logic                      reset,
    input  icache_pkg::addr_t         addr,
    input  logic                      hit,
    input  icache_pkg::mem_tag_t      mem_transaction_tag,
    input  icache_pkg::mem_tag_t      mem_data_tag,
    output icache_pkg::mem_command_t  mem_command,
    output icache_pkg::addr_t         mem_addr,
    output logic                      fill,
    output logic                      new_access
);

    import icache_pkg::*;

    ////////////////////
    // Change detection
    ////////////////////

    line_index_t cur_index;
    cache_tag_t  cur_tag;
    line_index_t last_index;
    cache_tag_t  last_tag;
    logic        last_valid;
    logic        addr_changed;

    assign cur_index = addr[`ICACHE_INDEX_BITS+2:3];
    assign cur_tag   = addr[`ICACHE_ADDR_TOP:`ICACHE_INDEX_BITS+3];

    // First address out of reset always counts as new
    assign addr_changed = !last_valid || (cur_index != last_index) || (cur_tag != last_tag);
    assign new_access   = addr_changed;

    ////////////////////
    // Miss tracking
    ////////////////////

    logic     miss_outstanding;   // Request not yet accepted by memory
    mem_tag_t mem_tag_q;          // Transaction we wait on, zero if none
    logic     unanswered_miss;
    logic     update_mem_tag;

    // Data for the captured tag, dropped if the address moved this cycle
    assign fill = (mem_tag_q != '0) && (mem_data_tag == mem_tag_q) && !addr_changed;

    // New miss starts a request, an outstanding one stays up while memory is busy
    assign unanswered_miss = addr_changed ? !hit
                                          : miss_outstanding && (mem_transaction_tag == '0);

    // Transaction tag is zero outside load cycles, so these loads also clear it
    assign update_mem_tag = addr_changed || miss_outstanding || fill;

    // Keep requesting until memory hands out a tag
    assign mem_command = (miss_outstanding && !addr_changed) ? MEM_LOAD : MEM_NONE;
    assign mem_addr    = {addr[31:3], 3'b000};

    always_ff @(posedge clock) begin
        if (reset) begin
            last_valid       <= 1'b0;
            last_index       <= '0;
            last_tag         <= '0;
            miss_outstanding <= 1'b0;
            mem_tag_q        <= '0;
        end else begin
            last_valid       <= 1'b1;
            last_index       <= cur_index;
            last_tag         <= cur_tag;
            miss_outstanding <= unanswered_miss;
            if (update_mem_tag) begin
                mem_tag_q <= mem_transaction_tag;
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // Fill only after memory accepted the request
    assert property (@(posedge clock) disable iff (reset)
        fill |-> (mem_tag_q != '0) && !miss_outstanding)
        else $error("icache_miss_ctrl: fill without an accepted transaction");

    // Quiet memory side on the first cycle out of reset
    assert property (@(posedge clock) $fell(reset) |-> mem_command == MEM_NONE)
        else $error("icache_miss_ctrl: memory command issued right after reset");

endmodule

/* src/icache_csr.sv */
`include "icache_config.svh"

module icache_csr (
    input  logic         clock,
    input  logic         reset,
    input  logic         cfg_req,
    input  logic         cfg_write,
    input  logic [1:0]   cfg_addr,
    input  logic [31:0]  cfg_wdata,
    output logic         cfg_ack,
    output logic [31:0]  cfg_rdata,
    input  logic         new_access,
    input  logic         hit,
    output logic         flush
);

    import icache_pkg::*;

    ////////////////////
    // Handshake FSM
    ////////////////////

    csr_state_t state;
    csr_state_t state_next;
    logic       access;

    // Request accepted only from idle, ack is low there
    assign access  = (state == CSR_IDLE) && cfg_req;
    assign cfg_ack = (state != CSR_IDLE);

    always_comb begin
        state_next = state;
        case (state)
            CSR_IDLE:      if (cfg_req) state_next = CSR_ACK;
            CSR_ACK:       state_next = cfg_req ? CSR_WAIT_DROP : CSR_IDLE;
            CSR_WAIT_DROP: if (!cfg_req) state_next = CSR_IDLE;
            default:       state_next = CSR_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= CSR_IDLE;
        end else begin
            state <= state_next;
        end
    end

    ////////////////////
    // Registers
    ////////////////////

    count_t hits;
    count_t misses;

    // One-cycle flush on a CTRL write with bit 0 set
    assign flush = access && cfg_write && (cfg_addr == `CSR_CTRL) && cfg_wdata[0];

    // Counted once per new fetch address, wrapping
    always_ff @(posedge clock) begin
        if (reset) begin
            hits   <= '0;
            misses <= '0;
        end else if (new_access) begin
            if (hit) hits <= hits + 1'b1;
            else     misses <= misses + 1'b1;
        end
    end

    // Read data captured on the access edge, held while ack is up
    always_ff @(posedge clock) begin
        if (access) begin
            case (cfg_addr)
                `CSR_HITS:   cfg_rdata <= hits;
                `CSR_MISSES: cfg_rdata <= misses;
                default:     cfg_rdata <= '0;  // CTRL and unmapped read as zero
            endcase
        end
    end

    // Ack rises only on the edge after a request was seen
    assert property (@(posedge clock) disable iff (reset)
        $rose(cfg_ack) |-> $past(cfg_req))
        else $error("icache_csr: ack raised without a request");

endmodule

/* src/icache_top.sv */
`include "icache_config.svh"

module icache_top (
    input  logic                      clock,
    input  logic                      reset,
    // Fetch side
    input  icache_pkg::addr_t         fetch_addr,
    output icache_pkg::mem_block_t    hit_data,
    output logic                      hit_valid,
    output icache_pkg::addr_t         next_invalid_line,
    // Memory side
    output icache_pkg::mem_command_t  mem_command,
    output icache_pkg::addr_t         mem_addr,
    input  icache_pkg::mem_tag_t      mem_transaction_tag,
    input  icache_pkg::mem_block_t    mem_data,
    input  icache_pkg::mem_tag_t      mem_data_tag,
    // Register port
    input  logic                      cfg_req,
    input  logic                      cfg_write,
    input  logic [1:0]                cfg_addr,
    input  logic [31:0]               cfg_wdata,
    output logic                      cfg_ack,
    output logic [31:0]               cfg_rdata
);

    import icache_pkg::*;

    line_index_t fetch_index;
    logic        fill;
    logic        flush;
    logic        new_access;

    // Line selected by the fetch address
    assign fetch_index = fetch_addr[`ICACHE_INDEX_BITS+2:3];

    ////////////////////
    // Cache datapath
    ////////////////////

    icache_tag_store tag_store_i (
        .clock             (clock),
        .reset             (reset),
        .flush             (flush),
        .addr              (fetch_addr),
        .fill              (fill),
        .hit               (hit_valid),
        .next_invalid_line (next_invalid_line)
    );

    // Block data, shown to fetch whenever the tag hits
    icache_data_array data_array_i (
        .clock      (clock),
        .read_index (fetch_index),
        .read_data  (hit_data),
        .fill       (fill),
        .fill_data  (mem_data)
    );

    ////////////////////
    // Control
    ////////////////////

    icache_miss_ctrl miss_ctrl_i (
        .clock               (clock),
        .reset               (reset),
        .addr                (fetch_addr),
        .hit                 (hit_valid),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_command         (mem_command),
        .mem_addr            (mem_addr),
        .fill                (fill),
        .new_access          (new_access)
    );

    icache_csr csr_i (
        .clock      (clock),
        .reset      (reset),
        .cfg_req    (cfg_req),
        .cfg_write  (cfg_write),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_ack    (cfg_ack),
        .cfg_rdata  (cfg_rdata),
        .new_access (new_access),
        .hit        (hit_valid),
        .flush      (flush)
    );

endmodule

/* tb/icache_mem_model.sv */
module icache_mem_model (
    input  logic                      clock,
    input  logic                      reset,
    input  icache_pkg::mem_command_t  mem_command,
    input  icache_pkg::addr_t         mem_addr,
    output icache_pkg::mem_tag_t      mem_transaction_tag,
    output icache_pkg::mem_block_t    mem_data,
    output icache_pkg::mem_tag_t      mem_data_tag
);

    import icache_pkg::*;

    // Cycles from accepted load to returned block
    localparam int LATENCY = 6;

    logic     busy;
    logic     accept;
    mem_tag_t next_tag;
    mem_tag_t pipe_tag [LATENCY];
    addr_t    pipe_addr [LATENCY];

    ////////////////////
    // Request side
    ////////////////////

    // Busy memory answers a load with tag zero
    assign accept              = (mem_command == MEM_LOAD) && !busy;
    assign mem_transaction_tag = accept ? next_tag : '0;

    ////////////////////
    // Return pipeline
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            busy     <= 1'b0;
            next_tag <= mem_tag_t'(1);
            for (int i = 0; i < LATENCY; i++) begin
                pipe_tag[i] <= '0;
            end
        end else begin
            // Roughly one load cycle in four is refused
            busy <= ($urandom % 4) == 0;
            // Tags run 1..15 and skip zero
            if (accept) begin
                next_tag <= (next_tag == '1) ? mem_tag_t'(1) : next_tag + mem_tag_t'(1);
            end
            pipe_tag[0]  <= accept ? next_tag : '0;
            pipe_addr[0] <= mem_addr;
            for (int i = 1; i < LATENCY; i++) begin
                pipe_tag[i]  <= pipe_tag[i-1];
                pipe_addr[i] <= pipe_addr[i-1];
            end
        end
    end

    // Block pattern, address on top and its inverse below
    assign mem_data_tag = pipe_tag[LATENCY-1];
    assign mem_data     = {pipe_addr[LATENCY-1], ~pipe_addr[LATENCY-1]};

endmodule

/* tb/icache_tb.sv */
`include "icache_config.svh"

module icache_tb;

    import icache_pkg::*;

    logic         clock;
    logic         reset;
    addr_t        fetch_addr;
    mem_block_t   hit_data;
    logic         hit_valid;
    addr_t        next_invalid_line;
    mem_command_t mem_command;
    addr_t        mem_addr;
    mem_tag_t     mem_transaction_tag;
    mem_block_t   mem_data;
    mem_tag_t     mem_data_tag;
    logic         cfg_req;
    logic         cfg_write;
    logic [1:0]   cfg_addr;
    logic [31:0]  cfg_wdata;
    logic         cfg_ack;
    logic [31:0]  cfg_rdata;

    int    check_errors;
    int    timeouts;
    addr_t visited [$];

    icache_top dut_i (
        .clock               (clock),
        .reset               (reset),
        .fetch_addr          (fetch_addr),
        .hit_data            (hit_data),
        .hit_valid           (hit_valid),
        .next_invalid_line   (next_invalid_line),
        .mem_command         (mem_command),
        .mem_addr            (mem_addr),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data            (mem_data),
        .mem_data_tag        (mem_data_tag),
        .cfg_req             (cfg_req),
        .cfg_write           (cfg_write),
        .cfg_addr            (cfg_addr),
        .cfg_wdata           (cfg_wdata),
        .cfg_ack             (cfg_ack),
        .cfg_rdata           (cfg_rdata)
    );

    icache_mem_model mem_i (
        .clock               (clock),
        .reset               (reset),
        .mem_command         (mem_command),
        .mem_addr            (mem_addr),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data            (mem_data),
        .mem_data_tag        (mem_data_tag)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    ////////////////////
    // Reference model
    ////////////////////

    logic [`ICACHE_LINES-1:0] model_valid;
    cache_tag_t               model_tag [`ICACHE_LINES];
    count_t                   model_hits;
    count_t                   model_misses;
    addr_t                    prev_addr;
    logic                     prev_valid;
    logic                     addr_change;
    logic                     model_hit;
    logic                     flush_cmd;
    logic [31:0]              exp_rdata;
    addr_t                    exp_nil;
    int                       miss_age;
    int                       ack_wait;
    int                       drop_wait;

    // Block rule, aligned address over its inverse
    function automatic mem_block_t block_pattern(addr_t a);
        addr_t base;
        base = {a[31:3], 3'b000};
        return {base, ~base};
    endfunction

    // Step upward through the lines, note a pass over the top one
    function automatic addr_t expected_next_invalid(addr_t a, logic [`ICACHE_LINES-1:0] v);
        line_index_t p;
        cache_tag_t  t;
        logic        wrapped;
        logic        found;
        int          step;
        p       = a[7:3];
        t       = a[15:8];
        wrapped = 1'b0;
        found   = 1'b0;
        step    = 0;
        while (!found && step < `ICACHE_LINES) begin
            if (!v[p]) begin
                found = 1'b1;
            end else begin
                if (p == '1) wrapped = 1'b1;
                p = p + 1'b1;
                step++;
            end
        end
        // A full cache ends back at the start, wrapped
        if (wrapped) t = t + 1'b1;
        return {a[31:16], t, p, 3'b000};
    endfunction

    // Three tags over all lines, so lines get replaced now and then
    function automatic addr_t random_addr();
        cache_tag_t  t;
        line_index_t idx;
        t   = 8'h10 + 8'($urandom_range(0, 2));
        idx = 5'($urandom_range(0, 31));
        return {16'h0000, t, idx, 3'($urandom_range(0, 7))};
    endfunction

    assign addr_change = !prev_valid || (fetch_addr[15:3] != prev_addr[15:3]);
    assign model_hit   = model_valid[fetch_addr[7:3]]
                         && (model_tag[fetch_addr[7:3]] == fetch_addr[15:8]);
    assign flush_cmd   = cfg_req && !cfg_ack && cfg_write && (cfg_addr == `CSR_CTRL) && cfg_wdata[0];
    assign exp_nil     = expected_next_invalid(fetch_addr, model_valid);

    always_ff @(posedge clock) begin
        if (reset) begin
            model_valid  <= '0;
            model_hits   <= '0;
            model_misses <= '0;
            prev_valid   <= 1'b0;
            prev_addr    <= '0;
        end else begin
            // Flush takes the edge where the request is first seen
            if (flush_cmd) begin
                model_valid <= '0;
            end else if (hit_valid && !model_hit) begin
                model_valid[fetch_addr[7:3]] <= 1'b1;
                model_tag[fetch_addr[7:3]]   <= fetch_addr[15:8];
            end
            if (addr_change) begin
                if (model_hit) model_hits <= model_hits + 1;
                else model_misses <= model_misses + 1;
            end
            prev_valid <= 1'b1;
            prev_addr  <= fetch_addr;
        end
    end

    // Read value latched on the access edge
    always_ff @(posedge clock) begin
        if (cfg_req && !cfg_ack) begin
            case (cfg_addr)
                `CSR_HITS:   exp_rdata <= model_hits;
                `CSR_MISSES: exp_rdata <= model_misses;
                default:     exp_rdata <= '0;
            endcase
        end
    end

    // Cycle counters for the timing rules
    always_ff @(posedge clock) begin
        if (reset || hit_valid || addr_change) miss_age <= 0;
        else miss_age <= miss_age + 1;
        if (!reset && cfg_req && !cfg_ack) ack_wait <= ack_wait + 1;
        else ack_wait <= 0;
        if (!reset && !cfg_req && cfg_ack) drop_wait <= drop_wait + 1;
        else drop_wait <= 0;
    end

    ////////////////////
    // Checks
    ////////////////////

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        check_errors++;
        $display("** Error @%0t: %s = %0h, expected %0h", $time, name, got, exp);
    endtask

    task automatic report_failure(input string what);
        check_errors++;
        $display("Failure at time %0t: %s", $time, what);
    endtask

    assert property (@(posedge clock) disable iff (reset)
        hit_valid |-> hit_data == block_pattern(fetch_addr))
        else report_mismatch("hit_data", $sampled(hit_data), block_pattern($sampled(fetch_addr)));

    assert property (@(posedge clock) disable iff (reset) miss_age < 40)
        else report_failure("a miss on a held address was not filled within 40 cycles");

    assert property (@(posedge clock) $fell(reset) |-> mem_command == MEM_NONE)
        else report_failure("a memory command was issued right after reset");

    // New addresses, abandoned ones included, hit only if the model says so
    assert property (@(posedge clock) disable iff (reset)
        addr_change |-> hit_valid == model_hit)
        else report_mismatch("hit_valid", $sampled(hit_valid), $sampled(model_hit));

    assert property (@(posedge clock) disable iff (reset) model_hit |-> hit_valid)
        else report_mismatch("hit_valid", $sampled(hit_valid), 1);

    assert property (@(posedge clock) disable iff (reset) model_hit |-> mem_command != MEM_LOAD)
        else report_failure("MEM_LOAD was issued for an address that hits");

    // Skip the one cycle where a fill is visible before the model learns it
    assert property (@(posedge clock) disable iff (reset)
        !(hit_valid && !model_hit) |-> next_invalid_line == exp_nil)
        else report_mismatch("next_invalid_line", $sampled(next_invalid_line), $sampled(exp_nil));

    assert property (@(posedge clock) disable iff (reset)
        cfg_ack && !cfg_write |-> cfg_rdata == exp_rdata)
        else report_mismatch("cfg_rdata", $sampled(cfg_rdata), $sampled(exp_rdata));

    assert property (@(posedge clock) disable iff (reset) $rose(cfg_ack) |-> $past(cfg_req))
        else report_failure("cfg_ack rose without a request");

    assert property (@(posedge clock) disable iff (reset) cfg_req && !cfg_ack |-> ack_wait == 0)
        else report_failure("cfg_ack did not follow cfg_req by one cycle");

    // Ack stays up as long as the request is held
    assert property (@(posedge clock) disable iff (reset) cfg_ack && cfg_req |=> cfg_ack)
        else report_failure("cfg_ack dropped while cfg_req was still high");

    assert property (@(posedge clock) disable iff (reset) drop_wait < 3)
        else report_failure("cfg_ack stayed high 3 cycles after cfg_req fell");

    ////////////////////
    // Stimulus
    ////////////////////

    // Present an address and hold it until the hit is seen on a rising edge
    task automatic fetch_and_wait(input addr_t a);
        int cycles;
        fetch_addr = a;
        cycles     = 0;
        @(negedge clock);
        while (!hit_valid && cycles < 40) begin
            @(negedge clock);
            cycles++;
        end
        if (!hit_valid) begin
            timeouts++;
            $display("Timeout: fetch of %h got no hit within 40 cycles", a);
        end
        @(negedge clock);
    endtask

    // Leave the address before the memory can answer
    task automatic abandon_fetch(input addr_t a, input int hold);
        fetch_addr = a;
        repeat (hold) @(negedge clock);
    endtask

    // One full four-phase transfer
    task automatic csr_access(input logic write, input logic [1:0] addr,
                              input logic [31:0] wdata);
        int cycles;
        cfg_req   = 1'b1;
        cfg_write = write;
        cfg_addr  = addr;
        cfg_wdata = wdata;
        cycles    = 0;
        @(negedge clock);
        while (!cfg_ack && cycles < 5) begin
            @(negedge clock);
            cycles++;
        end
        if (!cfg_ack) begin
            timeouts++;
            $display("Timeout: no cfg_ack for register %0d", addr);
        end
        // Request held one more cycle with ack up
        @(negedge clock);
        cfg_req = 1'b0;
        cycles  = 0;
        @(negedge clock);
        while (cfg_ack && cycles < 5) begin
            @(negedge clock);
            cycles++;
        end
        if (cfg_ack) begin
            timeouts++;
            $display("Timeout: cfg_ack stuck high after register %0d", addr);
        end
    endtask

    initial begin
        addr_t a;
        void'($urandom(32'h7acab5fb));
        reset        = 1'b1;
        fetch_addr   = '0;
        cfg_req      = 1'b0;
        cfg_write    = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        check_errors = 0;
        timeouts     = 0;
        repeat (5) @(negedge clock);
        reset = 1'b0;

        // Cold misses, then a second pass over the same blocks
        repeat (16) begin
            a = random_addr();
            visited.push_back(a);
            fetch_and_wait(a);
        end
        foreach (visited[i]) fetch_and_wait(visited[i]);

        // Abandoned miss must not leave its block behind
        abandon_fetch(32'h0000_a5c8, 3);
        fetch_and_wait(32'h0000_5a10);
        fetch_and_wait(32'h0000_a5c8);
        csr_access(1'b0, `CSR_HITS, '0);
        csr_access(1'b0, `CSR_MISSES, '0);

        // Flush with a hitting address held, then revisit everything
        csr_access(1'b1, `CSR_CTRL, 32'h1);
        fetch_and_wait(32'h0000_f008);
        foreach (visited[i]) fetch_and_wait(visited[i]);
        repeat (24) fetch_and_wait(random_addr());
        csr_access(1'b0, `CSR_CTRL, '0);
        csr_access(1'b0, `CSR_HITS, '0);
        csr_access(1'b0, `CSR_MISSES, '0);

        $display("Checks failed: %0d, timeouts: %0d", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+src
src/icache_pkg.sv
src/icache_data_array.sv
src/icache_tag_store.sv
src/icache_miss_ctrl.sv
src/icache_csr.sv
src/icache_top.sv
tb/icache_mem_model.sv
tb/icache_tb.sv

/* Makefile */
# Verilator build and regression run for the instruction cache

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module icache_tb -o Vicache_tb
	./obj_dir/Vicache_tb | tee sim.log
	grep -q "Regression passed" sim.log

lint:
	verilator --lint-only --timing -Wall -f project.f --top-module icache_tb

clean:
	rm -rf obj_dir sim.log
